// File: Makefile
TOP := tb_execute_unit

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --timescale 1ns/10ps --top-module $(TOP) -f list.f

sim:
	verilator --binary --timing --timescale 1ns/10ps --top-module $(TOP) -f list.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then exit 1; fi
	@grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: dv/execute_stimulus.txt
# id op src0 src1 imm imm_vld dst_reg dst_addr next_addr exp_data exp_status (hex except id)
# ret lines hold the expected ret_addr in next_addr; exp_data is unused for jmp, call, ret
1 add 12 34 00 0 1 000 000 46 04
2 add f0 20 00 0 2 000 000 10 05
3 add 80 77 80 1 3 000 000 00 09
4 add 05 77 0a 1 0 000 000 0f 04
5 sub 50 20 00 0 1 000 000 30 04
6 sub 20 50 00 0 2 000 000 d0 05
7 sub 33 77 33 1 3 000 000 00 08
8 sub 10 77 11 1 0 000 000 ff 05
9 or a0 05 00 0 1 000 000 a5 04
10 or 00 00 00 0 2 000 000 00 08
11 or 0f 77 f0 1 3 000 000 ff 04
12 and f0 3c 00 0 0 000 000 30 04
13 and aa 77 55 1 1 000 000 00 08
14 xor ff 0f 00 0 2 000 000 f0 04
15 xor 5a 77 5a 1 3 000 000 00 08
16 xor c3 77 3c 1 0 000 000 ff 04
17 mem_wr a7 00 00 0 0 123 000 a7 04
18 mem_wr 3c 00 00 0 0 fff 000 3c 04
19 mem_rd 00 00 00 0 2 123 000 a7 04
20 mem_rd 00 00 00 0 1 fff 000 3c 04
21 sub 44 44 00 0 0 000 000 00 08
22 mem_rd 00 00 00 0 3 123 000 a7 08
23 jmp 00 00 00 0 0 000 3a5 00 08
24 call 00 00 00 0 0 000 456 00 08
25 jmp 00 00 00 0 0 000 111 00 08
26 call 00 00 00 0 0 000 abc 00 08
27 ret 00 00 00 0 0 000 abc 00 08
28 ret 00 00 00 0 0 000 456 00 08
29 add 01 01 00 0 1 000 000 02 04
30 call 00 00 00 0 0 000 7f0 00 04
31 ret 00 00 00 0 0 000 7f0 00 04
32 mem_rd 00 00 00 0 2 800 000 07 04
33 mem_rd 00 00 00 0 3 801 000 f0 04
34 add ff 77 01 1 2 000 000 00 09
35 mem_wr 5e 00 00 0 1 0a0 000 5e 09
36 mem_rd 00 00 00 0 0 0a0 000 5e 09

// File: dv/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int error_count     = 0;
int check_count     = 0;
int test_pass_count = 0;
int test_fail_count = 0;

task automatic check_data(input string name, input data_t got, input data_t exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("ERROR at %0t: %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("ERROR at %0t: %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_sel(input string name, input reg_sel_t got, input reg_sel_t exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("ERROR at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
endtask

task automatic check_status(input string name, input status_t got, input status_t exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("ERROR at %0t: %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("ERROR at %0t: %s got %b expected %b", $time, name, got, exp);
    end
endtask

// one summary line per finished test
task automatic report_test(input int id, input string name, input int errors_before);
    if (error_count == errors_before) begin
        test_pass_count++;
        $display("test %0d %s: ok", id, name);
    end else begin
        test_fail_count++;
        $display("test %0d %s: %0d errors", id, name, error_count - errors_before);
    end
endtask

`endif

// File: dv/tb_execute_unit.sv
`timescale 1ns/10ps

module tb_execute_unit;
    import cpu_isa_pkg::*;
    import cpu_mem_pkg::*;

    localparam int    CYCLES_PER_TEST = 6;
    localparam int    TIMEOUT_MARGIN  = 50;
    localparam int    STIM_FIELDS     = 11;
    localparam string STIM_FILE       = "dv/execute_stimulus.txt";

    typedef struct {
        int       id;
        string    name;
        exec_op_t op;
        data_t    src0;
        data_t    src1;
        data_t    imm;
        logic     imm_vld;
        reg_sel_t dst_reg;
        addr_t    dst_addr;
        addr_t    next_addr;     // expected ret_addr on ret lines
        data_t    exp_data;
        status_t  exp_status;
    } stim_t;

    logic     clk;
    logic     reset_;
    logic     execute_en;
    exec_op_t exec_ctrl;
    reg_sel_t dst_reg;
    addr_t    dst_addr;
    addr_t    next_addr;
    data_t    reg_src0_data;
    data_t    reg_src1_data;
    data_t    imm_data;
    logic     imm_data_vld;
    data_t    d_mem_data_in;
    data_t    reg_wr_data;
    reg_sel_t reg_wr_sel;
    logic     reg_wr_en;
    addr_t    d_mem_addr;
    data_t    d_mem_data_out;
    logic     d_mem_en;
    logic     d_mem_rd;
    logic     d_mem_wr;
    logic     pc_branch;
    addr_t    ret_addr;
    logic     ret_addr_en;
    status_t  status_reg;

    data_t mem [0:4095];
    stim_t tests[$];
    sp_t   sp_model = '0;   // expected stack depth in bytes
    int    cycle_count = 0;
    int    timeout_limit = TIMEOUT_MARGIN;

    `include "tb_checks.svh"

    execute_unit execute_unit_inst (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // data memory with async read and write at the edge
    assign d_mem_data_in = mem[d_mem_addr];

    always @(posedge clk) begin
        if (d_mem_en && d_mem_wr) begin
            mem[d_mem_addr] <= d_mem_data_out;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("timeout: run did not finish within %0d cycles", timeout_limit);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    function automatic bit parse_op(input string name, output exec_op_t op);
        op = OP_NOP;
        case (name)
            "add":    op = OP_ADD;
            "sub":    op = OP_SUB;
            "or":     op = OP_OR;
            "and":    op = OP_AND;
            "xor":    op = OP_XOR;
            "mem_rd": op = OP_MEM_RD;
            "mem_wr": op = OP_MEM_WR;
            "jmp":    op = OP_JMP;
            "call":   op = OP_CALL;
            "ret":    op = OP_RET;
            default:  return 1'b0;
        endcase
        return 1'b1;
    endfunction

    task automatic load_stimulus();
        int         fd;
        int         line_no;
        int         fields;
        string      line;
        string      op_name;
        exec_op_t   op;
        logic [7:0] status_bits;
        stim_t      t;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            error_count++;
            $display("cannot open stimulus file %s", STIM_FILE);
            return;
        end
        line_no = 0;
        while ($fgets(line, fd) != 0) begin
            line_no++;
            if (line.len() < 2 || line.substr(0, 0) == "#") begin
                continue;   // blank or column description
            end
            fields = $sscanf(line, "%d %s %h %h %h %h %h %h %h %h %h", t.id, op_name,
                             t.src0, t.src1, t.imm, t.imm_vld, t.dst_reg, t.dst_addr,
                             t.next_addr, t.exp_data, status_bits);
            if (fields != STIM_FIELDS || !parse_op(op_name, op)) begin
                error_count++;
                $display("stimulus line %0d could not be parsed", line_no);
                continue;
            end
            t.op         = op;
            t.name       = op_name;
            t.exp_status = status_t'(status_bits);
            tests.push_back(t);
        end
        $fclose(fd);
        if (tests.size() == 0) begin
            error_count++;
            $display("no tests were read from the stimulus file");
        end
    endtask

    task automatic check_strobes(input logic en, input logic rd, input logic wr);
        check_bit("d_mem_en", d_mem_en, en);
        check_bit("d_mem_rd", d_mem_rd, rd);
        check_bit("d_mem_wr", d_mem_wr, wr);
    endtask

    task automatic check_idle_outputs();
        check_strobes(1'b0, 1'b0, 1'b0);
        check_bit("reg_wr_en", reg_wr_en, 1'b0);
        check_bit("pc_branch", pc_branch, 1'b0);
        check_bit("ret_addr_en", ret_addr_en, 1'b0);
        check_status("status_reg", status_reg, '0);
    endtask

    task automatic check_reset();
        int errors_before;
        errors_before = error_count;
        repeat (2) begin
            @(posedge clk);
            @(negedge clk);
            check_idle_outputs();
        end
        @(posedge clk);   // third edge with reset low
        #1;
        reset_ = 1'b1;
        @(negedge clk);
        check_idle_outputs();
        report_test(0, "reset", errors_before);
    endtask

    task automatic run_test(input stim_t t);
        int   errors_before;
        logic is_alu;
        errors_before = error_count;
        is_alu = t.op inside {OP_ADD, OP_SUB, OP_OR, OP_AND, OP_XOR};

        @(posedge clk);   // issue in cycle N
        #1;
        execute_en = 1'b1;
        exec_ctrl  = t.op;
        dst_reg    = t.dst_reg;
        dst_addr   = t.dst_addr;
        // a ret line holds the expected address, so the input gets other bits
        next_addr  = (t.op == OP_RET) ? ~t.next_addr : t.next_addr;
        @(negedge clk);
        check_bit("pc_branch", pc_branch, (t.op == OP_JMP) || (t.op == OP_CALL));

        @(posedge clk);   // operands in N+1
        #1;
        execute_en    = 1'b0;
        exec_ctrl     = OP_NOP;
        reg_src0_data = t.src0;
        reg_src1_data = t.src1;
        imm_data      = t.imm;
        imm_data_vld  = t.imm_vld;
        @(negedge clk);
        check_bit("pc_branch", pc_branch, 1'b0);
        check_bit("reg_wr_en", reg_wr_en, is_alu || (t.op == OP_MEM_RD));
        case (t.op)
            OP_MEM_WR: begin
                check_strobes(1'b1, 1'b0, 1'b1);
                check_addr("d_mem_addr", d_mem_addr, t.dst_addr);
                check_data("d_mem_data_out", d_mem_data_out, t.exp_data);
            end
            OP_MEM_RD: begin
                check_strobes(1'b1, 1'b1, 1'b0);
                check_addr("d_mem_addr", d_mem_addr, t.dst_addr);
                check_sel("reg_wr_sel", reg_wr_sel, t.dst_reg);
                check_data("reg_wr_data", reg_wr_data, t.exp_data);
            end
            OP_CALL: begin
                check_strobes(1'b1, 1'b0, 1'b1);
                check_addr("d_mem_addr", d_mem_addr, {4'h8, sp_model});
                check_data("d_mem_data_out", d_mem_data_out, {4'h0, t.next_addr[11:8]});
            end
            OP_RET: begin
                check_strobes(1'b1, 1'b1, 1'b0);
                check_addr("d_mem_addr", d_mem_addr, {4'h8, sp_model - 8'd1});
            end
            default: begin
                check_strobes(1'b0, 1'b0, 1'b0);
                if (is_alu) begin
                    check_sel("reg_wr_sel", reg_wr_sel, t.dst_reg);
                    check_data("reg_wr_data", reg_wr_data, t.exp_data);
                end
            end
        endcase

        @(posedge clk);   // N+2
        #1;
        reg_src0_data = '0;
        reg_src1_data = '0;
        imm_data      = '0;
        imm_data_vld  = 1'b0;
        @(negedge clk);
        check_status("status_reg", status_reg, t.exp_status);
        if (t.op == OP_CALL) begin
            check_strobes(1'b1, 1'b0, 1'b1);
            check_addr("d_mem_addr", d_mem_addr, {4'h8, sp_model + 8'd1});
            check_data("d_mem_data_out", d_mem_data_out, t.next_addr[7:0]);
            sp_model = sp_model + 8'd2;
        end else if (t.op == OP_RET) begin
            check_strobes(1'b1, 1'b1, 1'b0);
            check_addr("d_mem_addr", d_mem_addr, {4'h8, sp_model - 8'd2});
            check_bit("ret_addr_en", ret_addr_en, 1'b0);
            @(posedge clk);   // restored address in N+3
            @(negedge clk);
            check_bit("ret_addr_en", ret_addr_en, 1'b1);
            check_addr("ret_addr", ret_addr, t.next_addr);
            check_strobes(1'b0, 1'b0, 1'b0);
            sp_model = sp_model - 8'd2;
        end else begin
            check_strobes(1'b0, 1'b0, 1'b0);
            check_bit("reg_wr_en", reg_wr_en, 1'b0);
        end
        report_test(t.id, t.name, errors_before);
    endtask

    initial begin
        reset_        = 1'b0;
        execute_en    = 1'b0;
        exec_ctrl     = OP_NOP;
        dst_reg       = '0;
        dst_addr      = '0;
        next_addr     = '0;
        reg_src0_data = '0;
        reg_src1_data = '0;
        imm_data      = '0;
        imm_data_vld  = 1'b0;
        for (int a = 0; a < 4096; a++) begin
            mem[addr_t'(a)] <= data_t'(a ^ (a >> 4) ^ (a >> 8) ^ 'h5a);
        end

        load_stimulus();
        timeout_limit = tests.size() * CYCLES_PER_TEST + TIMEOUT_MARGIN;

        check_reset();
        foreach (tests[i]) begin
            run_test(tests[i]);
        end

        $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
                 test_pass_count, test_fail_count, check_count, error_count);
        if (error_count == 0 && test_fail_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+dv
verilog/cpu_isa_pkg.sv
verilog/cpu_mem_pkg.sv
verilog/exec_ctrl_if.sv
verilog/exec_sequencer.sv
verilog/stack_pointer.sv
verilog/alu_writeback.sv
verilog/mem_port.sv
verilog/execute_unit.sv
dv/tb_execute_unit.sv

// File: verilog/alu_writeback.sv
`timescale 1ns/10ps

module alu_writeback (
    input  logic                  clk,
    input  logic                  reset_,
    exec_ctrl_if.alu              ctrl,
    input  cpu_isa_pkg::data_t    reg_src0_data,
    input  cpu_isa_pkg::data_t    reg_src1_data,
    input  cpu_isa_pkg::data_t    imm_data,
    input  logic                  imm_data_vld,
    input  cpu_isa_pkg::data_t    d_mem_data_in,
    output cpu_isa_pkg::data_t    reg_wr_data,
    output cpu_isa_pkg::reg_sel_t reg_wr_sel,
    output logic                  reg_wr_en,
    output cpu_isa_pkg::status_t  status_reg
);
    import cpu_isa_pkg::*;

    data_t   src1;
    data_t   alu_result;
    logic    carry;        // carry or borrow out of bit 7
    logic    alu_op;
    logic    mem_rd_op;
    status_t status_next;

    assign src1 = imm_data_vld ? imm_data : reg_src1_data;

    always_comb begin
        carry      = 1'b0;
        alu_result = '0;
        case (ctrl.stage_op)
            OP_ADD:  {carry, alu_result} = {1'b0, reg_src0_data} + {1'b0, src1};
            OP_SUB:  {carry, alu_result} = {1'b0, reg_src0_data} - {1'b0, src1};
            OP_OR:   alu_result = reg_src0_data | src1;
            OP_AND:  alu_result = reg_src0_data & src1;
            OP_XOR:  alu_result = reg_src0_data ^ src1;
            default: alu_result = '0;
        endcase
    end

    always_comb begin
        case (ctrl.stage_op)
            OP_ADD, OP_SUB, OP_OR, OP_AND, OP_XOR: alu_op = ctrl.stage_valid;
            default:                               alu_op = 1'b0;
        endcase
    end

    assign mem_rd_op = ctrl.stage_valid & (ctrl.stage_op == OP_MEM_RD);

    always_comb begin
        status_next     = '0;
        status_next.z   = (alu_result == '0);
        status_next.nz  = (alu_result != '0);
        status_next.ovf = carry;  // zero for the logical ops
    end

    // flags only move on alu ops
    always_ff @(posedge clk) begin
        if (!reset_) begin
            status_reg <= '0;
        end else if (alu_op) begin
            status_reg <= status_next;
        end
    end

    // writeback in the operand cycle
    assign reg_wr_en   = alu_op | mem_rd_op;
    assign reg_wr_sel  = ctrl.stage_dst_reg;
    assign reg_wr_data = mem_rd_op ? d_mem_data_in : alu_result;

endmodule

// File: verilog/cpu_isa_pkg.sv
package cpu_isa_pkg;

    localparam int DATA_W = 8;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [1:0] reg_sel_t;  // destination register number

    typedef enum logic [3:0] {
        OP_NOP    = 4'd0,
        OP_ADD    = 4'd1,
        OP_SUB    = 4'd2,
        OP_OR     = 4'd3,
        OP_AND    = 4'd4,
        OP_XOR    = 4'd5,
        OP_MEM_RD = 4'd6,
        OP_MEM_WR = 4'd7,
        OP_JMP    = 4'd8,
        OP_CALL   = 4'd9,
        OP_RET    = 4'd10
    } exec_op_t;

    // status register layout with ovf in bit 0
    typedef struct packed {
        logic [3:0] rsvd_hi;
        logic       z;
        logic       nz;
        logic       rsvd;
        logic       ovf;
    } status_t;

endpackage

// File: verilog/cpu_mem_pkg.sv
package cpu_mem_pkg;

    localparam int ADDR_W = 12;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [7:0] sp_t;  // offset within the stack page

    // stack lives in h800..h8ff
    localparam logic [3:0] STACK_PAGE = 4'h8;

endpackage

// File: verilog/exec_ctrl_if.sv
`timescale 1ns/10ps

interface exec_ctrl_if;
    import cpu_isa_pkg::*;
    import cpu_mem_pkg::*;

    logic     save_ret;        // call seen at issue
    logic     stage_valid;
    exec_op_t stage_op;
    reg_sel_t stage_dst_reg;
    addr_t    stage_dst_addr;
    logic     push_hi;         // first call beat
    logic     push_lo;         // second call beat
    logic     pop_lo;          // first ret beat
    logic     pop_hi;          // second ret beat

    modport seq (
        output save_ret, stage_valid, stage_op, stage_dst_reg, stage_dst_addr,
        output push_hi, push_lo, pop_lo, pop_hi
    );

    modport alu (
        input stage_valid, stage_op, stage_dst_reg
    );

    modport mem (
        input save_ret, stage_valid, stage_op, stage_dst_reg, stage_dst_addr,
        input push_hi, push_lo, pop_lo, pop_hi
    );

    modport sp (
        input push_hi, push_lo, pop_lo, pop_hi
    );

endinterface

// File: verilog/exec_sequencer.sv
`timescale 1ns/10ps

module exec_sequencer (
    input  logic                 clk,
    input  logic                 reset_,
    input  logic                 execute_en,
    input  cpu_isa_pkg::exec_op_t exec_ctrl,
    input  cpu_isa_pkg::reg_sel_t dst_reg,
    input  cpu_mem_pkg::addr_t   dst_addr,
    output logic                 pc_branch,
    exec_ctrl_if.seq             ctrl
);
    import cpu_isa_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SECOND_PUSH,
        ST_SECOND_POP
    } seq_state_t;

    seq_state_t state;
    seq_state_t state_next;

    // issue cycle decode
    assign pc_branch     = execute_en & ((exec_ctrl == OP_JMP) | (exec_ctrl == OP_CALL));
    assign ctrl.save_ret = execute_en & (exec_ctrl == OP_CALL);

    // operands show up one cycle after issue, so hold the instruction here
    always_ff @(posedge clk) begin
        if (!reset_) begin
            ctrl.stage_valid <= 1'b0;
            ctrl.stage_op    <= OP_NOP;
        end else begin
            ctrl.stage_valid <= execute_en;
            ctrl.stage_op    <= exec_ctrl;
        end
    end

    always_ff @(posedge clk) begin
        ctrl.stage_dst_reg  <= dst_reg;   // payload
        ctrl.stage_dst_addr <= dst_addr;
    end

    // first stack beat comes straight from the staged op
    assign ctrl.push_hi = ctrl.stage_valid & (ctrl.stage_op == OP_CALL);
    assign ctrl.pop_lo  = ctrl.stage_valid & (ctrl.stage_op == OP_RET);

    // second beat from the fsm
    assign ctrl.push_lo = (state == ST_SECOND_PUSH);
    assign ctrl.pop_hi  = (state == ST_SECOND_POP);

    always_comb begin
        if (ctrl.push_hi) begin
            state_next = ST_SECOND_PUSH;
        end else if (ctrl.pop_lo) begin
            state_next = ST_SECOND_POP;
        end else begin
            state_next = ST_IDLE;  // second beats always fall back to idle
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

endmodule

// File: verilog/execute_unit.sv
`timescale 1ns/10ps

module execute_unit (
    input  logic                  clk,
    input  logic                  reset_,
    input  logic                  execute_en,
    input  cpu_isa_pkg::exec_op_t exec_ctrl,
    input  cpu_isa_pkg::reg_sel_t dst_reg,
    input  cpu_mem_pkg::addr_t    dst_addr,
    input  cpu_mem_pkg::addr_t    next_addr,
    input  cpu_isa_pkg::data_t    reg_src0_data,
    input  cpu_isa_pkg::data_t    reg_src1_data,
    input  cpu_isa_pkg::data_t    imm_data,
    input  logic                  imm_data_vld,
    input  cpu_isa_pkg::data_t    d_mem_data_in,
    output cpu_isa_pkg::data_t    reg_wr_data,
    output cpu_isa_pkg::reg_sel_t reg_wr_sel,
    output logic                  reg_wr_en,
    output cpu_mem_pkg::addr_t    d_mem_addr,
    output cpu_isa_pkg::data_t    d_mem_data_out,
    output logic                  d_mem_en,
    output logic                  d_mem_rd,
    output logic                  d_mem_wr,
    output logic                  pc_branch,
    output cpu_mem_pkg::addr_t    ret_addr,
    output logic                  ret_addr_en,
    output cpu_isa_pkg::status_t  status_reg
);
    import cpu_mem_pkg::*;

    addr_t stack_addr;

    exec_ctrl_if ctrl_if ();

    exec_sequencer exec_sequencer_inst (
        .clk        (clk),
        .reset_     (reset_),
        .execute_en (execute_en),
        .exec_ctrl  (exec_ctrl),
        .dst_reg    (dst_reg),
        .dst_addr   (dst_addr),
        .pc_branch  (pc_branch),
        .ctrl       (ctrl_if.seq)
    );

    stack_pointer stack_pointer_inst (
        .clk        (clk),
        .reset_     (reset_),
        .ctrl       (ctrl_if.sp),
        .stack_addr (stack_addr)
    );

    alu_writeback alu_writeback_inst (
        .clk           (clk),
        .reset_        (reset_),
        .ctrl          (ctrl_if.alu),
        .reg_src0_data (reg_src0_data),
        .reg_src1_data (reg_src1_data),
        .imm_data      (imm_data),
        .imm_data_vld  (imm_data_vld),
        .d_mem_data_in (d_mem_data_in),
        .reg_wr_data   (reg_wr_data),
        .reg_wr_sel    (reg_wr_sel),
        .reg_wr_en     (reg_wr_en),
        .status_reg    (status_reg)
    );

    mem_port mem_port_inst (
        .clk            (clk),
        .reset_         (reset_),
        .ctrl           (ctrl_if.mem),
        .next_addr      (next_addr),
        .stack_addr     (stack_addr),
        .reg_src0_data  (reg_src0_data),
        .d_mem_data_in  (d_mem_data_in),
        .d_mem_addr     (d_mem_addr),
        .d_mem_data_out (d_mem_data_out),
        .d_mem_en       (d_mem_en),
        .d_mem_rd       (d_mem_rd),
        .d_mem_wr       (d_mem_wr),
        .ret_addr       (ret_addr),
        .ret_addr_en    (ret_addr_en)
    );

endmodule

// File: verilog/mem_port.sv
`timescale 1ns/10ps

module mem_port (
    input  logic               clk,
    input  logic               reset_,
    exec_ctrl_if.mem           ctrl,
    input  cpu_mem_pkg::addr_t next_addr,
    input  cpu_mem_pkg::addr_t stack_addr,
    input  cpu_isa_pkg::data_t reg_src0_data,
    input  cpu_isa_pkg::data_t d_mem_data_in,
    output cpu_mem_pkg::addr_t d_mem_addr,
    output cpu_isa_pkg::data_t d_mem_data_out,
    output logic               d_mem_en,
    output logic               d_mem_rd,
    output logic               d_mem_wr,
    output cpu_mem_pkg::addr_t ret_addr,
    output logic               ret_addr_en
);
    import cpu_isa_pkg::*;

    logic [3:0] ret_hi;     // upper return address bits
    data_t      ret_lo;
    logic       mem_rd_op;
    logic       mem_wr_op;
    logic       stack_op;

    // return address is filled at call issue or from the stack on ret
    always_ff @(posedge clk) begin
        if (ctrl.save_ret) begin
            ret_hi <= next_addr[11:8];
            ret_lo <= next_addr[7:0];
        end else if (ctrl.pop_lo) begin
            ret_lo <= d_mem_data_in;
        end else if (ctrl.pop_hi) begin
            ret_hi <= d_mem_data_in[3:0];  // byte was stored zero-extended
        end
    end

    assign ret_addr = {ret_hi, ret_lo};

    // restored address is complete one cycle after the last pop
    always_ff @(posedge clk) begin
        if (!reset_) begin
            ret_addr_en <= 1'b0;
        end else begin
            ret_addr_en <= ctrl.pop_hi;
        end
    end

    assign mem_rd_op = ctrl.stage_valid & (ctrl.stage_op == OP_MEM_RD);
    assign mem_wr_op = ctrl.stage_valid & (ctrl.stage_op == OP_MEM_WR);
    assign stack_op  = ctrl.push_hi | ctrl.push_lo | ctrl.pop_lo | ctrl.pop_hi;

    assign d_mem_rd = mem_rd_op | ctrl.pop_lo | ctrl.pop_hi;
    assign d_mem_wr = mem_wr_op | ctrl.push_hi | ctrl.push_lo;
    assign d_mem_en = d_mem_rd | d_mem_wr;

    assign d_mem_addr = stack_op ? stack_addr : ctrl.stage_dst_addr;

    always_comb begin
        if (ctrl.push_hi) begin
            d_mem_data_out = {4'h0, ret_hi};  // high byte goes first
        end else if (ctrl.push_lo) begin
            d_mem_data_out = ret_lo;
        end else begin
            d_mem_data_out = reg_src0_data;
        end
    end

endmodule

// File: verilog/stack_pointer.sv
`timescale 1ns/10ps

module stack_pointer (
    input  logic               clk,
    input  logic               reset_,
    exec_ctrl_if.sp            ctrl,
    output cpu_mem_pkg::addr_t stack_addr
);
    import cpu_mem_pkg::*;

    sp_t  sp;
    sp_t  sp_below;   // top occupied entry
    logic push_beat;
    logic pop_beat;

    assign push_beat = ctrl.push_hi | ctrl.push_lo;
    assign pop_beat  = ctrl.pop_lo | ctrl.pop_hi;
    assign sp_below  = sp - 8'd1;

    always_ff @(posedge clk) begin
        if (!reset_) begin
            sp <= '0;
        end else if (push_beat) begin
            sp <= sp + 8'd1;  // wraps within the page
        end else if (pop_beat) begin
            sp <= sp_below;
        end
    end

    // push writes the free slot, pop reads the one below it
    assign stack_addr = push_beat ? {STACK_PAGE, sp} : {STACK_PAGE, sp_below};

endmodule
